// File: build.f
source/core_pkg.sv
source/stage_fifo.sv
source/inst_decoder.sv
source/alu.sv
source/reg_file.sv
source/execute_stage.sv
source/mem_stage.sv
source/core_top.sv
verif/tb_clock.sv
verif/core_properties.sv
verif/core_tb.sv

// File: source/alu.sv
`timescale 1ns/1ns

module alu import core_pkg::*; (
	input  alu_op_e i_op,
	input  word_t   i_a,
	input  word_t   i_b,
	output word_t   o_result
);

	logic [4:0] shamt;

	assign shamt = i_b[4:0];

	always_comb begin
		case (i_op)
			ALU_ADD:  o_result = i_a + i_b;
			ALU_SUB:  o_result = i_a - i_b;
			ALU_SLL:  o_result = i_a << shamt;
			ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
			ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, i_a < i_b};
			ALU_XOR:  o_result = i_a ^ i_b;
			ALU_SRL:  o_result = i_a >> shamt;
			// Arithmetic shift keeps the sign bit
			ALU_SRA:  o_result = word_t'($signed(i_a) >>> shamt);
			ALU_OR:   o_result = i_a | i_b;
			ALU_AND:  o_result = i_a & i_b;
			default:  o_result = '0;
		endcase
	end

endmodule

// File: source/core_pkg.sv
package core_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [4:0]      reg_idx_t;
	typedef logic [31:0]     inst_t;

	// Major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcode_e;

	typedef enum logic [2:0] {
		INST_R, INST_I, INST_S, INST_B, INST_U, INST_J, INST_X
	} inst_type_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	typedef struct packed {
		inst_type_e itype;
		alu_op_e    alu_op;
		logic [2:0] funct3;
		logic       is_lui;
		logic       is_jump;
		logic       is_load;
		logic       is_store;
		logic       is_branch;
		logic       rwb_en;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		reg_idx_t   rd;
	} inst_ctrl_t;

	typedef struct packed {
		addr_t      pc;
		inst_ctrl_t ctrl;
		word_t      imm;
	} ex_entry_t;

	typedef struct packed {
		addr_t      pc;
		inst_ctrl_t ctrl;
		word_t      imm;
		word_t      alu_result;
		word_t      rs2_data;
		logic       br_taken;
		addr_t      jump_target;
	} mem_entry_t;

	typedef struct packed {
		addr_t      pc;
		inst_ctrl_t ctrl;
		word_t      imm;
		word_t      alu_result;
		word_t      load_data;
	} wb_entry_t;

endpackage

// File: source/core_top.sv
`timescale 1ns/1ns

module core_top import core_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  i_inst_valid,
	input  addr_t i_inst_pc,
	input  inst_t i_inst_bits,
	output logic  o_inst_ready,
	output logic  o_redirect,
	output addr_t o_redirect_pc,
	output logic  o_dmem_en,
	output logic  o_dmem_we,
	output addr_t o_dmem_addr,
	output word_t o_dmem_wdata,
	input  word_t i_dmem_rdata,
	output word_t o_instret
);

	inst_ctrl_t id_ctrl;
	word_t      id_imm;
	ex_entry_t  exq_wdata;
	ex_entry_t  exq_rdata;
	logic       exq_rvalid;
	logic       exq_rready;
	mem_entry_t memq_wdata;
	mem_entry_t memq_rdata;
	logic       memq_wvalid;
	logic       memq_wready;
	logic       memq_rvalid;
	logic       memq_rready;
	wb_entry_t  wbq_wdata;
	wb_entry_t  wbq_rdata;
	logic       wbq_wvalid;
	logic       wbq_wready;
	logic       wbq_rvalid;
	reg_idx_t   ex_rs1;
	reg_idx_t   ex_rs2;
	word_t      rs1_data;
	word_t      rs2_data;
	reg_idx_t   mem_busy_rd;
	reg_idx_t   wb_busy_rd;
	word_t      wb_data;

	inst_decoder u_decoder (
		.i_bits (i_inst_bits),
		.o_ctrl (id_ctrl),
		.o_imm  (id_imm)
	);

	assign exq_wdata = '{pc: i_inst_pc, ctrl: id_ctrl, imm: id_imm};

	// Taken branch or jump in memory kills the two younger entries
	assign o_redirect    = memq_rvalid && (memq_rdata.ctrl.is_jump || memq_rdata.br_taken);
	assign o_redirect_pc = memq_rdata.jump_target;

	stage_fifo #(.DATA_TYPE(ex_entry_t)) u_exq (
		.clk      (clk),
		.rst      (rst),
		.i_flush  (o_redirect),
		.i_wvalid (i_inst_valid),
		.i_wdata  (exq_wdata),
		.o_wready (o_inst_ready),
		.i_rready (exq_rready),
		.o_rvalid (exq_rvalid),
		.o_rdata  (exq_rdata)
	);

	// Register numbers of writers still in flight or zero if none
	assign mem_busy_rd = (memq_rvalid && memq_rdata.ctrl.rwb_en) ? memq_rdata.ctrl.rd : '0;
	assign wb_busy_rd  = (wbq_rvalid && wbq_rdata.ctrl.rwb_en) ? wbq_rdata.ctrl.rd : '0;

	execute_stage u_execute (
		.i_valid       (exq_rvalid),
		.i_entry       (exq_rdata),
		.o_ready       (exq_rready),
		.o_valid       (memq_wvalid),
		.o_entry       (memq_wdata),
		.i_down_ready  (memq_wready),
		.o_rs1         (ex_rs1),
		.o_rs2         (ex_rs2),
		.i_rs1_data    (rs1_data),
		.i_rs2_data    (rs2_data),
		.i_mem_busy_rd (mem_busy_rd),
		.i_wb_busy_rd  (wb_busy_rd)
	);

	stage_fifo #(.DATA_TYPE(mem_entry_t)) u_memq (
		.clk      (clk),
		.rst      (rst),
		.i_flush  (o_redirect),
		.i_wvalid (memq_wvalid),
		.i_wdata  (memq_wdata),
		.o_wready (memq_wready),
		.i_rready (memq_rready),
		.o_rvalid (memq_rvalid),
		.o_rdata  (memq_rdata)
	);

	mem_stage u_mem (
		.clk          (clk),
		.rst          (rst),
		.i_valid      (memq_rvalid),
		.i_entry      (memq_rdata),
		.i_down_ready (wbq_wready),
		.o_ready      (memq_rready),
		.o_valid      (wbq_wvalid),
		.o_entry      (wbq_wdata),
		.o_dmem_en    (o_dmem_en),
		.o_dmem_we    (o_dmem_we),
		.o_dmem_addr  (o_dmem_addr),
		.o_dmem_wdata (o_dmem_wdata),
		.i_dmem_rdata (i_dmem_rdata)
	);

	// Writeback retires one entry every cycle it has one
	stage_fifo #(.DATA_TYPE(wb_entry_t)) u_wbq (
		.clk      (clk),
		.rst      (rst),
		.i_flush  (1'b0),
		.i_wvalid (wbq_wvalid),
		.i_wdata  (wbq_wdata),
		.o_wready (wbq_wready),
		.i_rready (1'b1),
		.o_rvalid (wbq_rvalid),
		.o_rdata  (wbq_rdata)
	);

	always_comb begin
		if (wbq_rdata.ctrl.is_lui) begin
			wb_data = wbq_rdata.imm;
		end else if (wbq_rdata.ctrl.is_jump) begin
			wb_data = wbq_rdata.pc + 32'd4;
		end else if (wbq_rdata.ctrl.is_load) begin
			wb_data = wbq_rdata.load_data;
		end else begin
			wb_data = wbq_rdata.alu_result;
		end
	end

	reg_file u_regs (
		.clk        (clk),
		.i_rs1      (ex_rs1),
		.i_rs2      (ex_rs2),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data),
		.i_we       (wbq_rvalid && wbq_rdata.ctrl.rwb_en),
		.i_rd       (wbq_rdata.ctrl.rd),
		.i_wdata    (wb_data)
	);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_instret <= '0;
		end else if (wbq_rvalid) begin
			o_instret <= o_instret + 1'b1;
		end
	end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import core_pkg::*; (
	input  logic       i_valid,
	input  ex_entry_t  i_entry,
	output logic       o_ready,
	output logic       o_valid,
	output mem_entry_t o_entry,
	input  logic       i_down_ready,
	output reg_idx_t   o_rs1,
	output reg_idx_t   o_rs2,
	input  word_t      i_rs1_data,
	input  word_t      i_rs2_data,
	input  reg_idx_t   i_mem_busy_rd,
	input  reg_idx_t   i_wb_busy_rd
);

	logic  rs1_busy;
	logic  rs2_busy;
	logic  hazard;
	logic  br_cond;
	word_t op_a;
	word_t op_b;
	word_t alu_result;

	assign o_rs1 = i_entry.ctrl.rs1;
	assign o_rs2 = i_entry.ctrl.rs2;

	// No forwarding, so wait until older writers have retired
	assign rs1_busy = (o_rs1 != '0) && (o_rs1 == i_mem_busy_rd || o_rs1 == i_wb_busy_rd);
	assign rs2_busy = (o_rs2 != '0) && (o_rs2 == i_mem_busy_rd || o_rs2 == i_wb_busy_rd);
	assign hazard   = rs1_busy || rs2_busy;

	assign o_ready = i_down_ready && !hazard;
	assign o_valid = i_valid && !hazard;

	always_comb begin
		case (i_entry.ctrl.itype)
			INST_R, INST_B: begin
				op_a = i_rs1_data;
				op_b = i_rs2_data;
			end
			INST_I, INST_S: begin
				op_a = i_rs1_data;
				op_b = i_entry.imm;
			end
			INST_U, INST_J: begin
				op_a = i_entry.pc;
				op_b = i_entry.imm;
			end
			default: begin
				op_a = '0;
				op_b = '0;
			end
		endcase
	end

	alu u_alu (
		.i_op     (i_entry.ctrl.alu_op),
		.i_a      (op_a),
		.i_b      (op_b),
		.o_result (alu_result)
	);

	always_comb begin
		case (i_entry.ctrl.funct3)
			3'b000: br_cond = i_rs1_data == i_rs2_data;
			3'b001: br_cond = i_rs1_data != i_rs2_data;
			3'b100: br_cond = $signed(i_rs1_data) < $signed(i_rs2_data);
			3'b101: br_cond = $signed(i_rs1_data) >= $signed(i_rs2_data);
			3'b110: br_cond = i_rs1_data < i_rs2_data;
			3'b111: br_cond = i_rs1_data >= i_rs2_data;
			default: br_cond = 1'b0;
		endcase
	end

	always_comb begin
		o_entry.pc = i_entry.pc;
		o_entry.ctrl = i_entry.ctrl;
		o_entry.imm = i_entry.imm;
		o_entry.alu_result = alu_result;
		o_entry.rs2_data = i_rs2_data;
		o_entry.br_taken = i_entry.ctrl.is_branch && br_cond;
		// JAL and JALR reuse the ALU sum
		if (i_entry.ctrl.is_branch) begin
			o_entry.jump_target = i_entry.pc + i_entry.imm;
		end else begin
			o_entry.jump_target = {alu_result[XLEN-1:1], 1'b0};
		end
	end

endmodule

// File: source/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder import core_pkg::*; (
	input  inst_t      i_bits,
	output inst_ctrl_t o_ctrl,
	output word_t      o_imm
);

	logic [2:0] funct3;
	logic [6:0] funct7;
	alu_op_e    reg_op;

	assign funct3 = i_bits[14:12];
	assign funct7 = i_bits[31:25];

	// Common to OP and OP-IMM, bit 30 picks SRA over SRL
	always_comb begin
		case (funct3)
			3'b000: reg_op = ALU_ADD;
			3'b001: reg_op = ALU_SLL;
			3'b010: reg_op = ALU_SLT;
			3'b011: reg_op = ALU_SLTU;
			3'b100: reg_op = ALU_XOR;
			3'b101: reg_op = funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110: reg_op = ALU_OR;
			default: reg_op = ALU_AND;
		endcase
	end

	always_comb begin
		o_ctrl = '0;
		o_ctrl.itype = INST_X;
		o_ctrl.alu_op = ALU_ADD;
		o_ctrl.funct3 = funct3;
		case (i_bits[6:0])
			OP_LUI: begin
				o_ctrl.itype = INST_U;
				o_ctrl.is_lui = 1'b1;
				o_ctrl.rwb_en = 1'b1;
			end
			OP_AUIPC: begin
				o_ctrl.itype = INST_U;
				o_ctrl.rwb_en = 1'b1;
			end
			OP_JAL: begin
				o_ctrl.itype = INST_J;
				o_ctrl.is_jump = 1'b1;
				o_ctrl.rwb_en = 1'b1;
			end
			OP_JALR: begin
				if (funct3 == 3'b000) begin
					o_ctrl.itype = INST_I;
					o_ctrl.is_jump = 1'b1;
					o_ctrl.rwb_en = 1'b1;
				end
			end
			OP_BRANCH: begin
				// 010 and 011 are not branch conditions
				if (funct3[2:1] != 2'b01) begin
					o_ctrl.itype = INST_B;
					o_ctrl.is_branch = 1'b1;
				end
			end
			OP_LOAD: begin
				if (funct3 == 3'b010) begin
					o_ctrl.itype = INST_I;
					o_ctrl.is_load = 1'b1;
					o_ctrl.rwb_en = 1'b1;
				end
			end
			OP_STORE: begin
				if (funct3 == 3'b010) begin
					o_ctrl.itype = INST_S;
					o_ctrl.is_store = 1'b1;
				end
			end
			OP_IMM: begin
				o_ctrl.itype = INST_I;
				o_ctrl.alu_op = reg_op;
				o_ctrl.rwb_en = 1'b1;
			end
			OP_REG: begin
				if (funct7 == 7'b0000000 ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
					o_ctrl.itype = INST_R;
					o_ctrl.alu_op = (funct3 == 3'b000 && funct7[5]) ? ALU_SUB : reg_op;
					o_ctrl.rwb_en = 1'b1;
				end
			end
			default: begin
			end
		endcase
		// Register numbers only where the format reads or writes them
		if (o_ctrl.itype inside {INST_R, INST_I, INST_S, INST_B}) begin
			o_ctrl.rs1 = i_bits[19:15];
		end
		if (o_ctrl.itype inside {INST_R, INST_S, INST_B}) begin
			o_ctrl.rs2 = i_bits[24:20];
		end
		if (o_ctrl.rwb_en) begin
			o_ctrl.rd = i_bits[11:7];
		end
	end

	always_comb begin
		case (o_ctrl.itype)
			INST_I: o_imm = {{20{i_bits[31]}}, i_bits[31:20]};
			INST_S: o_imm = {{20{i_bits[31]}}, i_bits[31:25], i_bits[11:7]};
			INST_B: o_imm = {{19{i_bits[31]}}, i_bits[31], i_bits[7],
				i_bits[30:25], i_bits[11:8], 1'b0};
			INST_U: o_imm = {i_bits[31:12], 12'b0};
			INST_J: o_imm = {{11{i_bits[31]}}, i_bits[31], i_bits[19:12],
				i_bits[20], i_bits[30:21], 1'b0};
			default: o_imm = '0;
		endcase
	end

endmodule

// File: source/mem_stage.sv
`timescale 1ns/1ns

module mem_stage import core_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_valid,
	input  mem_entry_t i_entry,
	input  logic       i_down_ready,
	output logic       o_ready,
	output logic       o_valid,
	output wb_entry_t  o_entry,
	output logic       o_dmem_en,
	output logic       o_dmem_we,
	output addr_t      o_dmem_addr,
	output word_t      o_dmem_wdata,
	input  word_t      i_dmem_rdata
);

	logic load_wait;
	logic stall;

	// Load holds here until its data returns a cycle later
	assign stall   = i_valid && i_entry.ctrl.is_load && !load_wait;
	assign o_ready = i_down_ready && !stall;
	assign o_valid = i_valid && !stall;

	assign o_dmem_en    = (i_valid && i_entry.ctrl.is_store) || stall;
	assign o_dmem_we    = i_valid && i_entry.ctrl.is_store;
	assign o_dmem_addr  = {i_entry.alu_result[XLEN-1:2], 2'b00};
	assign o_dmem_wdata = i_entry.rs2_data;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			load_wait <= 1'b0;
		end else if (i_valid && o_ready) begin
			load_wait <= 1'b0;
		end else if (stall) begin
			load_wait <= 1'b1;
		end
	end

	always_comb begin
		o_entry.pc = i_entry.pc;
		o_entry.ctrl = i_entry.ctrl;
		o_entry.imm = i_entry.imm;
		o_entry.alu_result = i_entry.alu_result;
		o_entry.load_data = i_dmem_rdata;
	end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ns

module reg_file import core_pkg::*; (
	input  logic     clk,
	input  reg_idx_t i_rs1,
	input  reg_idx_t i_rs2,
	output word_t    o_rs1_data,
	output word_t    o_rs2_data,
	input  logic     i_we,
	input  reg_idx_t i_rd,
	input  word_t    i_wdata
);

	word_t regs [32];

	// x0 reads as zero whatever was written to it
	assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

	always_ff @(posedge clk) begin
		if (i_we) begin
			regs[i_rd] <= i_wdata;
		end
	end

endmodule

// File: source/stage_fifo.sv
`timescale 1ns/1ns

module stage_fifo #(
	parameter type DATA_TYPE = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     i_flush,
	input  logic     i_wvalid,
	input  DATA_TYPE i_wdata,
	output logic     o_wready,
	input  logic     i_rready,
	output logic     o_rvalid,
	output DATA_TYPE o_rdata
);

	logic     full;
	DATA_TYPE data_q;

	// Slot can be refilled in the same cycle it is drained
	assign o_wready = !full || i_rready;
	assign o_rvalid = full;
	assign o_rdata  = data_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			full <= 1'b0;
		end else if (i_flush) begin
			full <= 1'b0;
		end else if (i_wvalid && o_wready) begin
			full <= 1'b1;
		end else if (i_rready) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_wvalid && o_wready) begin
			data_q <= i_wdata;
		end
	end

endmodule

// File: verif/core_properties.sv
`timescale 1ns/1ns

module core_properties import core_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  i_dmem_en,
	input  logic  i_dmem_we,
	input  logic  i_redirect,
	input  word_t i_instret
);

	int assert_failures = 0;

	// A write is always part of an access
	assert property (@(posedge clk) disable iff (!rst) i_dmem_we |-> i_dmem_en)
	else begin
		$error("Data write strobe high without enable");
		assert_failures++;
	end

	// Load data comes back in the wait cycle, no new request then
	assert property (@(posedge clk) disable iff (!rst)
		(i_dmem_en && !i_dmem_we) |=> !i_dmem_en)
	else begin
		$error("Data port request in the cycle after a load request");
		assert_failures++;
	end

	assert property (@(posedge clk) disable iff (!rst)
		1'b1 |=> (i_instret - $past(i_instret) <= 32'd1))
	else begin
		$error("Retire counter grew by more than one in a cycle");
		assert_failures++;
	end

	// One pulse per taken branch or jump
	assert property (@(posedge clk) disable iff (!rst) i_redirect |=> !i_redirect)
	else begin
		$error("Redirect held for two consecutive cycles");
		assert_failures++;
	end

endmodule

// File: verif/core_tb.sv
`timescale 1ns/1ns

module core_tb import core_pkg::*; ();

	localparam int MARKER_ADDR = 'h7fc;
	localparam int RUN_LIMIT   = 2000;
	localparam int DRAIN_LIMIT = 20;

	logic  clk;
	logic  rst = 1'b0;
	logic  inst_valid = 1'b0;
	addr_t inst_pc = '0;
	inst_t inst_bits = '0;
	logic  inst_ready;
	logic  redirect;
	addr_t redirect_pc;
	logic  dmem_en;
	logic  dmem_we;
	addr_t dmem_addr;
	word_t dmem_wdata;
	word_t dmem_rdata = '0;
	word_t instret;

	// Fetch and data memory model state
	inst_t prog [$];
	word_t dmem [addr_t];
	addr_t fetch_pc = '0;
	logic  rst_s;
	logic  fire;
	logic  redir;
	addr_t redir_pc;
	logic  d_en;
	logic  d_we;
	addr_t d_addr;
	word_t d_wdata;
	logic  marker_seen = 1'b0;
	addr_t st_addr [$];
	word_t st_data [$];
	addr_t redir_log [$];

	// Expected results of the current program
	addr_t exp_addr [$];
	word_t exp_data [$];
	addr_t exp_redir [$];
	int    exp_retired = 0;
	int    errors = 0;
	int    timeouts = 0;

	tb_clock #(.PERIOD_NS(40)) u_clock (
		.o_clk (clk)
	);

	core_top u_dut (
		.clk           (clk),
		.rst           (rst),
		.i_inst_valid  (inst_valid),
		.i_inst_pc     (inst_pc),
		.i_inst_bits   (inst_bits),
		.o_inst_ready  (inst_ready),
		.o_redirect    (redirect),
		.o_redirect_pc (redirect_pc),
		.o_dmem_en     (dmem_en),
		.o_dmem_we     (dmem_we),
		.o_dmem_addr   (dmem_addr),
		.o_dmem_wdata  (dmem_wdata),
		.i_dmem_rdata  (dmem_rdata),
		.o_instret     (instret)
	);

	bind core_top core_properties u_props (
		.clk        (clk),
		.rst        (rst),
		.i_dmem_en  (o_dmem_en),
		.i_dmem_we  (o_dmem_we),
		.i_redirect (o_redirect),
		.i_instret  (o_instret)
	);

	function automatic word_t read_word(addr_t a);
		return dmem.exists(a) ? dmem[a] : (a ^ 32'h5a5a_c3c3);
	endfunction

	// Outputs sampled mid-cycle and inputs updated 2 ns after the edge
	always begin
		@(negedge clk);
		rst_s = rst;
		fire = inst_valid && inst_ready;
		redir = redirect;
		redir_pc = redirect_pc;
		d_en = dmem_en;
		d_we = dmem_we;
		d_addr = dmem_addr;
		d_wdata = dmem_wdata;
		@(posedge clk);
		#2;
		if (!rst_s) begin
			fetch_pc = '0;
		end else begin
			// The flush drops the word accepted with a redirect
			if (redir) begin
				fetch_pc = redir_pc;
				redir_log.push_back(redir_pc);
			end else if (fire) begin
				fetch_pc = fetch_pc + 32'd4;
			end
			if (d_en && d_we) begin
				dmem[d_addr] = d_wdata;
				st_addr.push_back(d_addr);
				st_data.push_back(d_wdata);
				if (d_addr == MARKER_ADDR) begin
					marker_seen = 1'b1;
				end
			end else if (d_en) begin
				dmem_rdata = read_word(d_addr);
			end
		end
		inst_valid = rst_s && (fetch_pc[31:2] < prog.size());
		inst_pc = fetch_pc;
		inst_bits = inst_valid ? prog[fetch_pc[31:2]] : '0;
	end

	function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3, reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
		reg_idx_t rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic inst_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic inst_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic inst_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic inst_t enc_j(logic [20:0] imm, reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// RV32I integer rules where alt selects SUB and SRA
	function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
		word_t r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: r = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic branch_model(logic [2:0] f3, word_t a, word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(string name, addr_t got, addr_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	function automatic addr_t next_pc();
		return addr_t'(prog.size() * 4);
	endfunction

	task automatic emit(inst_t w);
		prog.push_back(w);
		exp_retired++;
	endtask

	// Wrong-path word that never retires
	task automatic emit_skipped(inst_t w);
		prog.push_back(w);
	endtask

	task automatic emit_store(reg_idx_t rs, int addr, word_t data);
		emit(enc_s(addr[11:0], rs, 5'd0));
		exp_addr.push_back(addr_t'(addr));
		exp_data.push_back(data);
	endtask

	task automatic load_const(reg_idx_t rd, word_t v);
		word_t hi;
		hi = v + 32'h800;
		emit(enc_u(hi[31:12], rd, 7'b0110111));
		emit(enc_i(v[11:0], rd, 3'b000, rd, 7'b0010011));
	endtask

	// Holds the core in reset while a new program is built
	task automatic new_program();
		@(posedge clk);
		#2;
		rst = 1'b0;
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		exp_redir.delete();
		exp_retired = 0;
	endtask

	task automatic release_reset();
		repeat (2) @(posedge clk);
		#2;
		st_addr.delete();
		st_data.delete();
		redir_log.delete();
		marker_seen = 1'b0;
		rst = 1'b1;
	endtask

	task automatic compare_logs();
		int i;
		if (st_addr.size() != exp_addr.size()) begin
			errors++;
			$display("Data port saw %0d stores, expected %0d", st_addr.size(), exp_addr.size());
		end
		for (i = 0; i < st_addr.size() && i < exp_addr.size(); i++) begin
			check_addr("o_dmem_addr", st_addr[i], exp_addr[i]);
			check_word("o_dmem_wdata", st_data[i], exp_data[i]);
		end
		if (redir_log.size() != exp_redir.size()) begin
			errors++;
			$display("Core redirected %0d times, expected %0d", redir_log.size(), exp_redir.size());
		end
		for (i = 0; i < redir_log.size() && i < exp_redir.size(); i++) begin
			check_addr("o_redirect_pc", redir_log[i], exp_redir[i]);
		end
	endtask

	// Ends every program with a store to the marker address
	task automatic run_program();
		int cycles;
		emit_store(5'd0, MARKER_ADDR, '0);
		release_reset();
		cycles = 0;
		while (!marker_seen && cycles < RUN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!marker_seen) begin
			timeouts++;
			$display("Timeout: the program never reached its final store");
		end else begin
			cycles = 0;
			while (instret != word_t'(exp_retired) && cycles < DRAIN_LIMIT) begin
				@(negedge clk);
				cycles++;
			end
			check_word("o_instret", instret, word_t'(exp_retired));
			compare_logs();
		end
	endtask

	task automatic test_reset_state();
		new_program();
		release_reset();
		@(negedge clk);
		check_bit("o_redirect", redirect, 1'b0);
		check_bit("o_dmem_en", dmem_en, 1'b0);
		check_bit("o_dmem_we", dmem_we, 1'b0);
		check_bit("o_inst_ready", inst_ready, 1'b1);
		check_word("o_instret", instret, '0);
	endtask

	task automatic test_alu_ops();
		word_t a;
		word_t b;
		word_t r;
		word_t base;
		logic [11:0] imm;
		logic [2:0] f3;
		logic alt;
		int n;
		new_program();
		a = $urandom;
		b = $urandom;
		load_const(5'd1, a);
		load_const(5'd2, b);
		for (n = 0; n < 10; n++) begin
			f3 = (n < 8) ? 3'(n) : ((n == 8) ? 3'd0 : 3'd5);
			alt = (n >= 8);
			r = alu_model(f3, alt, a, b);
			emit(enc_r(alt ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f3, 5'd3));
			emit_store(5'd3, 'h100 + n * 4, r);
		end
		base = r;
		// Undecodable word still retires
		emit(32'hffff_ffff);
		for (n = 0; n < 9; n++) begin
			f3 = (n == 8) ? 3'd5 : 3'(n);
			alt = (n == 8);
			imm = 12'($urandom);
			if (f3 == 3'd1 || f3 == 3'd5) begin
				imm = {1'b0, alt, 5'b0, imm[4:0]};
			end
			r = alu_model(f3, alt, base, {{20{imm[11]}}, imm});
			emit(enc_i(imm, 5'd3, f3, 5'd4, 7'b0010011));
			emit_store(5'd4, 'h180 + n * 4, r);
		end
		run_program();
	endtask

	task automatic test_load_store();
		word_t pre;
		word_t c;
		new_program();
		pre = $urandom;
		c = $urandom;
		dmem[32'h200] = pre;
		emit(enc_i(12'h200, 5'd0, 3'b000, 5'd5, 7'b0010011));
		emit(enc_i(12'h000, 5'd5, 3'b010, 5'd6, 7'b0000011));
		load_const(5'd7, c);
		emit(enc_r(7'b0000000, 5'd7, 5'd6, 3'b000, 5'd8));
		emit_store(5'd8, 'h204, pre + c);
		// Low address bits are dropped on the data port
		emit(enc_i(12'h002, 5'd5, 3'b010, 5'd9, 7'b0000011));
		emit_store(5'd9, 'h208, pre);
		emit(enc_i(12'h07b, 5'd0, 3'b000, 5'd0, 7'b0010011));
		emit_store(5'd0, 'h20c, '0);
		run_program();
	endtask

	task automatic test_branches();
		word_t a;
		word_t b;
		word_t va;
		word_t vb;
		addr_t pc;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic [2:0] conds [6];
		int p;
		int c;
		int k;
		conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		new_program();
		// Negative against positive splits signed and unsigned order
		a = $urandom | 32'h8000_0000;
		b = $urandom & 32'h7fff_ffff;
		load_const(5'd1, a);
		load_const(5'd2, b);
		k = 0;
		for (p = 0; p < 3; p++) begin
			for (c = 0; c < 6; c++) begin
				rs1 = (p == 1) ? 5'd2 : 5'd1;
				rs2 = (p == 0) ? 5'd2 : 5'd1;
				va = (rs1 == 5'd1) ? a : b;
				vb = (rs2 == 5'd1) ? a : b;
				pc = next_pc();
				emit(enc_b(13'd8, rs2, rs1, conds[c]));
				if (branch_model(conds[c], va, vb)) begin
					exp_redir.push_back(pc + 32'd8);
					emit_skipped(enc_s(12'h3f0, 5'd1, 5'd0));
				end else begin
					emit_store(5'd1, 'h300 + k * 4, a);
				end
				k++;
			end
		end
		pc = next_pc();
		emit(enc_j(21'd12, 5'd10));
		emit_skipped(enc_s(12'h3f0, 5'd1, 5'd0));
		emit_skipped(enc_s(12'h3f4, 5'd1, 5'd0));
		emit_store(5'd10, 'h380, pc + 32'd4);
		exp_redir.push_back(pc + 32'd12);
		// Odd offset so that bit 0 of the target gets cleared
		pc = next_pc();
		emit(enc_u(20'd0, 5'd11, 7'b0010111));
		emit(enc_i(12'd13, 5'd11, 3'b000, 5'd12, 7'b1100111));
		emit_skipped(enc_s(12'h3f8, 5'd1, 5'd0));
		emit_store(5'd12, 'h384, pc + 32'd8);
		exp_redir.push_back(pc + 32'd12);
		run_program();
	endtask

	task automatic test_upper_imm();
		logic [19:0] u1;
		logic [19:0] u2;
		addr_t pc;
		new_program();
		u1 = 20'($urandom);
		u2 = 20'($urandom);
		emit(enc_i(12'h000, 5'd0, 3'b000, 5'd0, 7'b0010011));
		pc = next_pc();
		emit(enc_u(u1, 5'd14, 7'b0010111));
		emit_store(5'd14, 'h400, pc + {u1, 12'b0});
		emit(enc_u(u2, 5'd15, 7'b0110111));
		emit_store(5'd15, 'h404, {u2, 12'b0});
		run_program();
	endtask

	initial begin
		void'($urandom(32'h45b3_1d7c));
		test_reset_state();
		test_alu_ops();
		test_load_store();
		test_branches();
		test_upper_imm();
		$display("Checks failed: %0d, timeouts: %0d, assertion failures: %0d",
			errors, timeouts, u_dut.u_props.assert_failures);
		if (errors == 0 && timeouts == 0 && u_dut.u_props.assert_failures == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
	end

	always begin
		#(PERIOD_NS / 2) o_clk = ~o_clk;
	end

endmodule
